/* design/sdmac_map_pkg.sv */
// SDMAC register map
package sdmac_map_pkg;

  // Bus widths
  localparam int DATA_W = 32;          // CPU data bus
  localparam int ADDR_W = 8;           // Decoded low address bits

  // Register byte offsets inside the SDMAC window
  localparam logic [ADDR_W-1:0] WTC_OFS     = 8'h04;  // Word transfer count
  localparam logic [ADDR_W-1:0] CNTR_OFS    = 8'h08;  // Control register
  localparam logic [ADDR_W-1:0] ACR_OFS     = 8'h0C;  // Address register, also RAMSEY ACR
  localparam logic [ADDR_W-1:0] ST_DMA_OFS  = 8'h10;  // Start DMA action
  localparam logic [ADDR_W-1:0] FLUSH_OFS   = 8'h14;  // Flush action
  localparam logic [ADDR_W-1:0] CLR_INT_OFS = 8'h18;  // Clear interrupt action
  localparam logic [ADDR_W-1:0] ISTR_OFS    = 8'h1C;  // Interrupt status
  localparam logic [ADDR_W-1:0] VERSION_OFS = 8'h20;  // Read-only version word
  localparam logic [ADDR_W-1:0] SP_DMA_OFS  = 8'h3C;  // Stop DMA action
  localparam logic [ADDR_W-1:0] SSPBDAT_OFS = 8'h58;  // Peripheral bus data latch
  localparam logic [ADDR_W-1:0] DSP_OFS     = 8'h5C;  // Latch read with clear

  // WD33C93 register window, upper nibble
  localparam logic [3:0] WD_PAGE = 4'h4;

  // Fixed identification word
  localparam logic [DATA_W-1:0] VERSION_VAL = 32'h5344_0003;

  // Register sizes
  localparam int CNTR_W = 9;           // Control register bits
  localparam int SSPB_W = 8;           // Peripheral data byte

  // Values after reset
  localparam logic [CNTR_W-1:0] CNTR_RST = '0;
  localparam logic [DATA_W-1:0] ACR_RST  = '0;
  localparam logic [DATA_W-1:0] WTC_RST  = '0;
  localparam logic [SSPB_W-1:0] SSPB_RST = '0;

endpackage

/* design/sdmac_ctrl_pkg.sv */
// SDMAC control and status definitions
package sdmac_ctrl_pkg;

  // DMA engine state, read back in CNTR bits 10:9
  typedef enum logic [1:0] {
    DMA_IDLE   = 2'd0,   // No transfer
    DMA_ACTIVE = 2'd1,   // Transfer running
    DMA_FLUSH  = 2'd2    // Draining before idle
  } dma_state_t;

  // Control register bit positions
  localparam int CNTR_DDIR  = 1;       // Transfer direction
  localparam int CNTR_INTEN = 2;       // Interrupt enable

  // Interrupt status register
  localparam int ISTR_W     = 8;
  localparam int ISTR_FE    = 0;       // Flush done
  localparam int ISTR_E_INT = 1;       // End of DMA
  localparam int ISTR_INTS  = 4;       // SCSI interrupt pin, live
  localparam int ISTR_INT_F = 5;       // Any interrupt pending

  // Flush length in sclk cycles
  localparam int FLUSH_CYCLES = 4;

  // Down-counter width for the flush
  localparam int FLUSH_CNT_W = (FLUSH_CYCLES > 1) ? $clog2(FLUSH_CYCLES) : 1;

endpackage

/* design/addr_decoder.sv */
// SDMAC address decoder
`timescale 1ns/10ps

module addr_decoder import sdmac_map_pkg::*; (
  input  logic [ADDR_W-1:0] addr,     // CPU address, low byte
  input  logic              dmac_n,   // Chip select
  input  logic              as_n,     // Address strobe
  input  logic              rw,       // High for read

  output logic              acr_dec,  // Raw ACR hit for RAMSEY
  output logic              wdregreq, // WD33C93 window hit

  output logic              wtc_rd_n,
  output logic              contr_rd_n,
  output logic              istr_rd_n,
  output logic              sspbdat_rd_n,
  output logic              version_rd_n,
  output logic              dsp_rd_n,

  output logic              contr_wr,
  output logic              acr_wr,
  output logic              sspbdat_wr,

  output logic              st_dma,
  output logic              sp_dma,
  output logic              clr_int,
  output logic              flush_n    // Low requests a flush
);

  logic addr_valid;                    // Both selects low
  logic hit_wtc, hit_cntr, hit_st, hit_flush, hit_clr;
  logic hit_istr, hit_ver, hit_sp, hit_sspb, hit_dsp;

  assign addr_valid = ~(dmac_n | as_n);

  // One compare per mapped offset
  assign hit_wtc   = addr_valid & (addr == WTC_OFS);
  assign hit_cntr  = addr_valid & (addr == CNTR_OFS);
  assign acr_dec   = addr_valid & (addr == ACR_OFS);     // rw not used here
  assign hit_st    = addr_valid & (addr == ST_DMA_OFS);
  assign hit_flush = addr_valid & (addr == FLUSH_OFS);
  assign hit_clr   = addr_valid & (addr == CLR_INT_OFS);
  assign hit_istr  = addr_valid & (addr == ISTR_OFS);
  assign hit_ver   = addr_valid & (addr == VERSION_OFS);
  assign hit_sp    = addr_valid & (addr == SP_DMA_OFS);
  assign hit_sspb  = addr_valid & (addr == SSPBDAT_OFS);
  assign hit_dsp   = addr_valid & (addr == DSP_OFS);

  // Whole 4x page goes to the SCSI chip
  assign wdregreq = addr_valid & (addr[ADDR_W-1:ADDR_W-4] == WD_PAGE);

  // Read strobes, active low
  assign wtc_rd_n     = ~(hit_wtc  & rw);
  assign contr_rd_n   = ~(hit_cntr & rw);
  assign istr_rd_n    = ~(hit_istr & rw);
  assign sspbdat_rd_n = ~(hit_sspb & rw);
  assign version_rd_n = ~(hit_ver  & rw);
  assign dsp_rd_n     = ~(hit_dsp  & rw);

  // Write strobes, active high
  assign contr_wr   = hit_cntr & ~rw;
  assign acr_wr     = acr_dec  & ~rw;
  assign sspbdat_wr = hit_sspb & ~rw;

  // Actions fire on any access direction
  assign st_dma  = hit_st;
  assign sp_dma  = hit_sp;
  assign clr_int = hit_clr;
  assign flush_n = ~hit_flush;

endmodule

/* design/control_regs.sv */
// SDMAC CPU-written registers
`timescale 1ns/10ps

module control_regs import sdmac_map_pkg::*, sdmac_ctrl_pkg::*; (
  input  logic              sclk,
  input  logic              rst,
  input  logic [DATA_W-1:0] data_in,    // CPU write data
  input  logic              contr_wr,   // CNTR write
  input  logic              acr_wr,     // ACR write
  input  logic              sspbdat_wr, // Peripheral latch write
  input  logic              dsp_rd_n,   // Latch read with clear

  output logic [CNTR_W-1:0] cntr,
  output logic [DATA_W-1:0] acr,
  output logic [DATA_W-1:0] wtc,
  output logic [SSPB_W-1:0] sspbdat,
  output logic              dma_dir     // Direction to the data path
);

  logic dsp_rd_q;                       // DSP read seen last cycle
  logic dsp_done;                       // Trailing edge of a DSP read

  // Latch clears once the CPU lets go of the DSP read,
  // so the byte stays on the bus for the whole cycle
  assign dsp_done = dsp_rd_q & dsp_rd_n;

  always_ff @(posedge sclk) begin
    if (rst) begin
      dsp_rd_q <= 1'b0;
    end else begin
      dsp_rd_q <= ~dsp_rd_n;
    end
  end

  // Control register
  always_ff @(posedge sclk) begin
    if (rst) begin
      cntr <= CNTR_RST;
    end else if (contr_wr) begin
      cntr <= data_in[CNTR_W-1:0];      // Upper bits ignored
    end
  end

  // Address register and transfer count
  always_ff @(posedge sclk) begin
    if (rst) begin
      acr <= ACR_RST;
      wtc <= WTC_RST;
    end else if (acr_wr) begin
      acr <= data_in;
      wtc <= data_in;                   // Count mirrors the loaded address
    end
  end

  // Peripheral bus data latch
  always_ff @(posedge sclk) begin
    if (rst) begin
      sspbdat <= SSPB_RST;
    end else if (sspbdat_wr) begin
      sspbdat <= data_in[SSPB_W-1:0];   // Write wins over clear
    end else if (dsp_done) begin
      sspbdat <= SSPB_RST;
    end
  end

  assign dma_dir = cntr[CNTR_DDIR];     // 1 means host to SCSI

endmodule

/* design/dma_sequencer.sv */
// SDMAC DMA state machine
`timescale 1ns/10ps

module dma_sequencer import sdmac_ctrl_pkg::*; (
  input  logic              sclk,
  input  logic              rst,
  input  logic              st_dma,     // Start request level
  input  logic              sp_dma,     // Stop request level
  input  logic              clr_int,    // Clear interrupt level
  input  logic              flush_n,    // Flush request, low active
  input  logic              scsi_int,   // WD33C93 interrupt pin

  output dma_state_t        dma_state,
  output logic              dma_active,
  output logic [ISTR_W-1:0] istr
);

  logic st_q, sp_q, clr_q, fl_q;        // Strobes one cycle back
  logic st_rise, sp_rise, clr_rise, fl_rise;
  logic flush_req;
  logic [FLUSH_CNT_W-1:0] flush_cnt;    // Remaining flush cycles
  logic fe_q;                           // Flush done flag
  logic eint_q;                         // End of DMA flag

  assign flush_req = ~flush_n;

  // Remember each strobe so a long bus cycle acts once
  always_ff @(posedge sclk) begin
    if (rst) begin
      st_q  <= 1'b0;
      sp_q  <= 1'b0;
      clr_q <= 1'b0;
      fl_q  <= 1'b0;
    end else begin
      st_q  <= st_dma;
      sp_q  <= sp_dma;
      clr_q <= clr_int;
      fl_q  <= flush_req;
    end
  end

  assign st_rise  = st_dma    & ~st_q;
  assign sp_rise  = sp_dma    & ~sp_q;
  assign clr_rise = clr_int   & ~clr_q;
  assign fl_rise  = flush_req & ~fl_q;

  always_ff @(posedge sclk) begin
    if (rst) begin
      dma_state <= DMA_IDLE;
      flush_cnt <= '0;
      fe_q      <= 1'b0;
      eint_q    <= 1'b0;
    end else begin
      case (dma_state)
        DMA_IDLE: begin
          if (st_rise) begin
            dma_state <= DMA_ACTIVE;    // Flush here is ignored
          end
        end
        DMA_ACTIVE: begin
          if (sp_rise) begin
            dma_state <= DMA_IDLE;
            eint_q    <= 1'b1;          // Stop ends the transfer
          end else if (fl_rise) begin
            dma_state <= DMA_FLUSH;
            flush_cnt <= FLUSH_CNT_W'(FLUSH_CYCLES - 1);
          end
        end
        DMA_FLUSH: begin
          if (flush_cnt == '0) begin
            dma_state <= DMA_IDLE;
            fe_q      <= 1'b1;          // Drain complete
          end else begin
            flush_cnt <= flush_cnt - 1'b1;
          end
        end
        default: dma_state <= DMA_IDLE;
      endcase
      // Clear takes both sticky flags down
      if (clr_rise) begin
        fe_q   <= 1'b0;
        eint_q <= 1'b0;
      end
    end
  end

  assign dma_active = (dma_state != DMA_IDLE);  // Also high while flushing

  // Status word, unused bits read zero
  always_comb begin
    istr             = '0;
    istr[ISTR_FE]    = fe_q;
    istr[ISTR_E_INT] = eint_q;
    istr[ISTR_INTS]  = scsi_int;
    istr[ISTR_INT_F] = fe_q | eint_q | scsi_int;
  end

endmodule

/* design/bus_response.sv */
// SDMAC read data and interrupt
`timescale 1ns/10ps

module bus_response import sdmac_map_pkg::*, sdmac_ctrl_pkg::*; (
  input  logic              wtc_rd_n,
  input  logic              contr_rd_n,
  input  logic              istr_rd_n,
  input  logic              sspbdat_rd_n,
  input  logic              version_rd_n,
  input  logic              dsp_rd_n,
  input  logic [CNTR_W-1:0] cntr,
  input  logic [DATA_W-1:0] acr,        // Write-only on the bus
  input  logic [DATA_W-1:0] wtc,
  input  logic [SSPB_W-1:0] sspbdat,
  input  logic [ISTR_W-1:0] istr,
  input  dma_state_t        dma_state,

  output logic [DATA_W-1:0] data_out,
  output logic              data_oe,    // CPU data bus drive enable
  output logic              irq
);

  // Strobes are one-hot, priority only keeps synthesis simple
  always_comb begin
    data_out = '0;
    if (!wtc_rd_n) begin
      data_out = wtc;
    end else if (!contr_rd_n) begin
      data_out = DATA_W'({dma_state, cntr});   // State in bits 10:9
    end else if (!istr_rd_n) begin
      data_out = DATA_W'(istr);
    end else if (!version_rd_n) begin
      data_out = VERSION_VAL;
    end else if (!sspbdat_rd_n || !dsp_rd_n) begin
      data_out = DATA_W'(sspbdat);
    end
  end

  assign data_oe = ~(wtc_rd_n & contr_rd_n & istr_rd_n &
                     sspbdat_rd_n & version_rd_n & dsp_rd_n);

  assign irq = istr[ISTR_INT_F] & cntr[CNTR_INTEN];  // Masked by INTEN

endmodule

/* design/sdmac_top.sv */
// SDMAC register block top
`timescale 1ns/10ps

module sdmac_top import sdmac_map_pkg::*, sdmac_ctrl_pkg::*; (
  input  logic              sclk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] addr,
  input  logic              dmac_n,
  input  logic              as_n,
  input  logic              rw,
  input  logic [DATA_W-1:0] data_in,
  input  logic              scsi_int,

  output logic [DATA_W-1:0] data_out,
  output logic              data_oe,
  output logic              irq,
  output logic              dma_active,
  output logic              dma_dir,
  output logic              wdregreq,
  output logic              ramsey_acr
);

  // Decoder strobes
  logic wtc_rd_n, contr_rd_n, istr_rd_n, sspbdat_rd_n, version_rd_n, dsp_rd_n;
  logic contr_wr, acr_wr, sspbdat_wr;
  logic st_dma, sp_dma, clr_int, flush_n;

  // Register and status values
  logic [CNTR_W-1:0] cntr;
  logic [DATA_W-1:0] acr;
  logic [DATA_W-1:0] wtc;
  logic [SSPB_W-1:0] sspbdat;
  logic [ISTR_W-1:0] istr;
  dma_state_t        dma_state;

  addr_decoder u_dec (
    .addr, .dmac_n, .as_n, .rw,
    .acr_dec (ramsey_acr), .wdregreq,
    .wtc_rd_n, .contr_rd_n, .istr_rd_n, .sspbdat_rd_n, .version_rd_n, .dsp_rd_n,
    .contr_wr, .acr_wr, .sspbdat_wr,
    .st_dma, .sp_dma, .clr_int, .flush_n
  );

  control_regs u_regs (
    .sclk, .rst, .data_in, .contr_wr, .acr_wr, .sspbdat_wr, .dsp_rd_n,
    .cntr, .acr, .wtc, .sspbdat, .dma_dir
  );

  dma_sequencer u_seq (
    .sclk, .rst, .st_dma, .sp_dma, .clr_int, .flush_n, .scsi_int,
    .dma_state, .dma_active, .istr
  );

  bus_response u_resp (
    .wtc_rd_n, .contr_rd_n, .istr_rd_n, .sspbdat_rd_n, .version_rd_n, .dsp_rd_n,
    .cntr, .acr, .wtc, .sspbdat, .istr, .dma_state,
    .data_out, .data_oe, .irq
  );

endmodule

/* tb/tb_sdmac.sv */
// SDMAC bus-cycle testbench
`timescale 1ns/10ps

module tb_sdmac import sdmac_map_pkg::*, sdmac_ctrl_pkg::*;;

  localparam int NUM_ROWS = 26;
  localparam int MAX_HOLD = 8;                 // Longest row, the active flush
  localparam int T_CLK    = 20;
  localparam int LIMIT_NS = (16 + NUM_ROWS * (MAX_HOLD + 1 + FLUSH_CYCLES)) * T_CLK + 1000;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              rw;
    logic [DATA_W-1:0] wdata;
    logic              sint;                   // scsi_int level for the row
    logic [DATA_W-1:0] exp_data;
    logic              exp_oe;
    logic              exp_irq;
    logic              exp_act;                // dma_active at the check
    logic [7:0]        hold;                   // Cycles with the selects low
  } row_t;

  logic              sclk, rst, dmac_n, as_n, rw, scsi_int;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data_in, data_out;
  logic              data_oe, irq, dma_active, dma_dir, wdregreq, ramsey_acr;

  row_t              rows [NUM_ROWS];
  int                n_rows, n_checks, n_errors, row_errors;
  integer            seed;
  logic [DATA_W-1:0] rnd;                      // Random SSPBDAT write word
  logic              dir_model;                // DDIR as last written

  sdmac_top dut (
    .sclk, .rst, .addr, .dmac_n, .as_n, .rw, .data_in, .scsi_int,
    .data_out, .data_oe, .irq, .dma_active, .dma_dir, .wdregreq, .ramsey_acr
  );

  initial sclk = 1'b0;
  always #(T_CLK / 2) sclk = ~sclk;

  task automatic add_row(input logic [ADDR_W-1:0] a, input logic r, input logic [DATA_W-1:0] wd,
                         input logic si, input logic [DATA_W-1:0] ed, input logic eo,
                         input logic ei, input logic ea, input int h);
    if (n_rows < NUM_ROWS) begin
      rows[n_rows] = {a, r, wd, si, ed, eo, ei, ea, h[7:0]};
    end
    n_rows++;
  endtask

  task automatic compare(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      row_errors++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    r = rows[idx];
    row_errors = 0;
    @(posedge sclk);
    addr     <= r.addr;
    rw       <= r.rw;
    data_in  <= r.wdata;
    scsi_int <= r.sint;
    as_n     <= 1'b0;
    dmac_n   <= 1'b0;
    if (r.addr == CNTR_OFS && !r.rw) dir_model = r.wdata[CNTR_DDIR];
    repeat (r.hold - 1) @(posedge sclk);
    @(negedge sclk);                           // Last held cycle, outputs settled
    compare("data_out", data_out, r.exp_data);
    compare("data_oe", data_oe, r.exp_oe);
    compare("irq", irq, r.exp_irq);
    compare("dma_active", dma_active, r.exp_act);
    compare("dma_dir", dma_dir, dir_model);
    compare("ramsey_acr", ramsey_acr, r.addr == ACR_OFS);  // Raw ACR decode
    compare("wdregreq", wdregreq, r.addr[ADDR_W-1:ADDR_W-4] == WD_PAGE);
    @(posedge sclk);
    as_n   <= 1'b1;                            // One idle cycle before the next row
    dmac_n <= 1'b1;
    if (row_errors == 0) begin
      $display("row %0d addr %h rw %0d passed", idx, r.addr, r.rw);
    end else begin
      $display("row %0d addr %h rw %0d failed, %0d errors", idx, r.addr, r.rw, row_errors);
    end
    n_errors += row_errors;
  endtask

  initial begin
    rst       = 1'b1;
    dmac_n    = 1'b1;
    as_n      = 1'b1;
    rw        = 1'b1;
    addr      = '0;
    data_in   = '0;
    scsi_int  = 1'b0;
    n_rows    = 0;
    n_checks  = 0;
    n_errors  = 0;
    dir_model = 1'b0;
    seed      = 32'h0825_54e9;
    rnd       = $random(seed);
    // Decode and write
    add_row(CNTR_OFS, 0, 32'h0000_0206, 0, 32'h0, 0, 0, 0, 2);  // Bit 9 dropped
    add_row(ACR_OFS, 0, 32'h00C0_FFEE, 0, 32'h0, 0, 0, 0, 2);
    add_row(CNTR_OFS, 1, 32'h0, 0, 32'h0000_0006, 1, 0, 0, 2);
    add_row(WTC_OFS, 1, 32'h0, 0, 32'h00C0_FFEE, 1, 0, 0, 2);  // Copied from ACR
    add_row(8'h30, 1, 32'h0, 0, 32'h0, 0, 0, 0, 2);            // Unused offset
    add_row(8'h42, 1, 32'h0, 0, 32'h0, 0, 0, 0, 2);            // WD33C93 page
    add_row(VERSION_OFS, 1, 32'h0, 0, VERSION_VAL, 1, 0, 0, 2);
    // Start and stop
    add_row(ST_DMA_OFS, 0, 32'h0, 0, 32'h0, 0, 0, 1, 4);       // Long cycle acts once
    add_row(CNTR_OFS, 1, 32'h0, 0, 32'h0000_0206, 1, 0, 1, 2); // Active in 10:9
    add_row(SP_DMA_OFS, 0, 32'h0, 0, 32'h0, 0, 1, 0, 3);
    add_row(ISTR_OFS, 1, 32'h0, 0, 32'h0000_0022, 1, 1, 0, 2); // E_INT and INT_F
    add_row(CNTR_OFS, 0, 32'h0000_0002, 0, 32'h0, 0, 0, 0, 2); // INTEN off masks irq
    add_row(CLR_INT_OFS, 0, 32'h0, 0, 32'h0, 0, 0, 0, 2);
    // Flush
    add_row(ST_DMA_OFS, 0, 32'h0, 0, 32'h0, 0, 0, 1, 2);
    add_row(FLUSH_OFS, 0, 32'h0, 0, 32'h0, 0, 0, 0, MAX_HOLD);
    add_row(ISTR_OFS, 1, 32'h0, 0, 32'h0000_0021, 1, 0, 0, 2); // FE and INT_F
    add_row(FLUSH_OFS, 0, 32'h0, 0, 32'h0, 0, 0, 0, 2);        // Idle, stays inactive
    add_row(ISTR_OFS, 1, 32'h0, 0, 32'h0000_0021, 1, 0, 0, 2);
    // Clear and live interrupt
    add_row(CLR_INT_OFS, 0, 32'h0, 0, 32'h0, 0, 0, 0, 2);
    add_row(ISTR_OFS, 1, 32'h0, 1, 32'h0000_0030, 1, 0, 0, 2); // INTS and INT_F
    add_row(CNTR_OFS, 0, 32'h0000_0004, 1, 32'h0, 0, 1, 0, 2);
    add_row(ISTR_OFS, 1, 32'h0, 0, 32'h0, 1, 0, 0, 2);
    // Peripheral data latch, low byte only
    add_row(SSPBDAT_OFS, 0, rnd, 0, 32'h0, 0, 0, 0, 2);
    add_row(SSPBDAT_OFS, 1, 32'h0, 0, {24'h0, rnd[7:0]}, 1, 0, 0, 2);
    add_row(DSP_OFS, 1, 32'h0, 0, {24'h0, rnd[7:0]}, 1, 0, 0, 2);   // Clears after
    add_row(SSPBDAT_OFS, 1, 32'h0, 0, 32'h0, 1, 0, 0, 2);
    if (n_rows != NUM_ROWS) begin
      $display("Stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
      n_errors++;
    end
    repeat (16) @(posedge sclk);
    rst <= 1'b0;
    @(negedge sclk);
    row_errors = 0;
    compare("dma_active", dma_active, 1'b0);
    compare("irq", irq, 1'b0);
    compare("data_oe", data_oe, 1'b0);
    $display("reset values checked, %0d errors", row_errors);
    n_errors += row_errors;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from rows, longest hold and flush length
  initial begin
    #(LIMIT_NS);
    $display("Timeout: bus cycles did not finish within %0d ns", LIMIT_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* tb.f */
design/sdmac_map_pkg.sv
design/sdmac_ctrl_pkg.sv
design/addr_decoder.sv
design/control_regs.sv
design/dma_sequencer.sv
design/bus_response.sv
design/sdmac_top.sv
tb/tb_sdmac.sv
